/* src/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    // command codes whose bits map onto AluCtrlInternal below
    typedef enum logic [4:0] {
        ADD  = 5'b00000, // also left shift when a == b
        SUB  = 5'b11000, // carry set means no borrow
        XOR  = 5'b00100,
        XNOR = 5'b01100, // also not when a == 0
        COMP = 5'b01000, // a - b - 1 with carry set when a > b
        AND  = 5'b00101,
        OR   = 5'b00110
    } AluCmd;

    typedef struct packed {
        logic       carry_in;      // carry into bit 0
        logic       b_inv;         // use ~b
        logic       carry_disable; // logic ops ignore the carry chain
        logic [1:0] cmd;           // cell mux select with 0 xor, 1 and, 2 or
    } AluCtrlInternal;

    // one command word seen as a code or as cell controls
    typedef union packed {
        AluCmd          cmd;
        AluCtrlInternal ctrl;
    } AluCtrl;

    typedef enum logic [1:0] {
        REG_A      = 2'd0,
        REG_B      = 2'd1,
        REG_CMD    = 2'd2,
        REG_STATUS = 2'd3  // read only
    } reg_addr_e;

    // true for the seven legal command codes
    function automatic logic is_cmd(logic [4:0] code);
        logic ok;
        case (code)
            ADD, SUB, XOR, XNOR, COMP, AND, OR: ok = 1'b1;
            default:                            ok = 1'b0;
        endcase
        return ok;
    endfunction

endpackage

`default_nettype wire

/* src/full_adder.sv */
`default_nettype none

module full_adder (
    input  wire logic                    data1,
    input  wire logic                    data2,
    input  wire logic                    carry_in,
    input  wire alu_pkg::AluCtrlInternal ctrl,
    output logic                         ret,
    output logic                         gen,
    output logic                         propagate
);

    logic data2_sel;
    logic carry_gated;
    logic half_sum;
    logic func;

    assign data2_sel   = data2 ^ ctrl.b_inv;               // subtract and xnor flip b
    assign carry_gated = carry_in & ~ctrl.carry_disable;

    assign gen       = data1 & data2_sel;
    assign propagate = data1 | data2_sel;

    // a ^ b from the two terms already built for lookahead
    assign half_sum = ~gen & propagate;

    always_comb begin
        case (ctrl.cmd)
            2'd0:    func = half_sum;
            2'd1:    func = gen;        // and
            2'd2:    func = propagate;  // or
            default: func = 1'b0;       // unused select
        endcase
    end

    assign ret = func ^ carry_gated;

endmodule

`default_nettype wire

/* src/alu.sv */
`default_nettype none

module alu (
    input  wire logic [3:0]      d1,
    input  wire logic [3:0]      d2,
    input  wire alu_pkg::AluCtrl ctrl,
    output logic [3:0]           res,
    output logic                 carry_out
);

    logic [3:0] gen;
    logic [3:0] propagate;
    logic [4:0] carry;
    logic       cin;

    assign cin      = ctrl.ctrl.carry_in;
    assign carry[0] = cin;

    for (genvar i = 0; i < 4; i++) begin : g_bit
        full_adder fa_i (
            .data1     (d1[i]),
            .data2     (d2[i]),
            .carry_in  (carry[i]),
            .ctrl      (ctrl.ctrl),
            .ret       (res[i]),
            .gen       (gen[i]),
            .propagate (propagate[i])
        );
    end

    // two level lookahead with every carry straight from g, p and cin
    assign carry[1] = gen[0] | (cin & propagate[0]);

    assign carry[2] = gen[1]
                    | (gen[0] & propagate[1])
                    | (cin & propagate[0] & propagate[1]);

    assign carry[3] = gen[2]
                    | (gen[1] & propagate[2])
                    | (gen[0] & propagate[1] & propagate[2])
                    | (cin & propagate[0] & propagate[1] & propagate[2]);

    assign carry[4] = gen[3]
                    | (gen[2] & propagate[3])
                    | (gen[1] & propagate[2] & propagate[3])
                    | (gen[0] & propagate[1] & propagate[2] & propagate[3])
                    | (cin & propagate[0] & propagate[1] & propagate[2] & propagate[3]);

    assign carry_out = carry[4] & ~ctrl.ctrl.carry_disable; // logic ops report no carry

endmodule

`default_nettype wire

/* src/alu_chain.sv */
`default_nettype none

module alu_chain #(
    parameter int SLICES = 4
) (
    input  wire logic [4*SLICES-1:0] op_a,
    input  wire logic [4*SLICES-1:0] op_b,
    input  wire alu_pkg::AluCtrl     ctrl,
    output logic [4*SLICES-1:0]      res,
    output logic                     carry_out,
    output logic                     zero
);

    import alu_pkg::*;

    localparam int WIDTH = 4 * SLICES;

    logic [SLICES:1] slice_carry; // carry out of slice s-1

    for (genvar s = 0; s < SLICES; s++) begin : g_slice
        AluCtrl slice_ctrl;

        if (s == 0) begin : g_first
            assign slice_ctrl = ctrl;
        end else begin : g_next
            // ripple between slices through the carry_in field
            always_comb begin
                slice_ctrl = ctrl;
                slice_ctrl.ctrl.carry_in = slice_carry[s];
            end
        end

        alu alu_i (
            .d1        (op_a[4*s +: 4]),
            .d2        (op_b[4*s +: 4]),
            .ctrl      (slice_ctrl),
            .res       (res[4*s +: 4]),
            .carry_out (slice_carry[s+1])
        );
    end

    assign carry_out = slice_carry[SLICES];
    assign zero      = (res == {WIDTH{1'b0}});

    // the register block filters bad codes so the chain never sees one
    always_comb begin
        if (!$isunknown(ctrl)) begin
            assert (is_cmd(ctrl))
                else $error("alu_chain: illegal command %b", ctrl);
        end
    end

endmodule

`default_nettype wire

/* src/alu_regs.sv */
`default_nettype none

module alu_regs #(
    parameter int SLICES = 4
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                wr,
    input  wire alu_pkg::reg_addr_e  addr,
    input  wire logic [4*SLICES-1:0] wdata,
    input  wire logic                start,
    output logic [4*SLICES+1:0]      rdata,
    output logic                     done,
    output logic [4*SLICES-1:0]      op_a,
    output logic [4*SLICES-1:0]      op_b,
    output alu_pkg::AluCtrl          ctrl,
    input  wire logic [4*SLICES-1:0] res,
    input  wire logic                carry_out,
    input  wire logic                zero
);

    import alu_pkg::*;

    localparam int WIDTH = 4 * SLICES;

    logic [WIDTH-1:0] res_q;
    logic             carry_q;
    logic             zero_q;
    logic             cmd_ok;

    assign cmd_ok = is_cmd(wdata[4:0]);

    // host writes
    always_ff @(posedge clk) begin
        if (rst) begin
            op_a <= '0;
            op_b <= '0;
            ctrl <= '0;  // ADD
        end else if (wr) begin
            case (addr)
                REG_A:   op_a <= wdata;
                REG_B:   op_b <= wdata;
                REG_CMD: begin
                    if (cmd_ok) begin
                        ctrl <= wdata[4:0];
                    end
                end
                default: ;  // status is read only
            endcase
        end
    end

    // capture on start while the chain still sees the pre-write operands
    always_ff @(posedge clk) begin
        if (rst) begin
            res_q   <= '0;
            carry_q <= 1'b0;
            zero_q  <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= start;  // one cycle pulse per start
            if (start) begin
                res_q   <= res;
                carry_q <= carry_out;
                zero_q  <= zero;
            end
        end
    end

    always_comb begin
        case (addr)
            REG_A:   rdata = {2'b00, op_a};
            REG_B:   rdata = {2'b00, op_b};
            REG_CMD: rdata = {{(WIDTH - 3){1'b0}}, ctrl};
            default: rdata = {res_q, carry_q, zero_q};
        endcase
    end

    // every done belongs to the start one cycle before it
    a_done_follows_start: assert property (
        @(posedge clk) disable iff (rst)
        done |-> $past(start)
    ) else $error("alu_regs: done without start");

    a_status_read_only: assert property (
        @(posedge clk) disable iff (rst)
        (wr && addr == REG_STATUS) |=> ($stable(op_a) && $stable(op_b) && $stable(ctrl))
    ) else $error("alu_regs: write to status changed a register");

endmodule

`default_nettype wire

/* src/alu_top.sv */
`default_nettype none

module alu_top #(
    parameter int SLICES = 4
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                wr,
    input  wire alu_pkg::reg_addr_e  addr,
    input  wire logic [4*SLICES-1:0] wdata,
    input  wire logic                start,
    output logic [4*SLICES+1:0]      rdata,
    output logic                     done
);

    import alu_pkg::*;

    localparam int WIDTH = 4 * SLICES;

    logic [WIDTH-1:0] op_a;
    logic [WIDTH-1:0] op_b;
    AluCtrl           ctrl;
    logic [WIDTH-1:0] res;
    logic             carry_out;
    logic             zero;

    alu_regs #(.SLICES(SLICES)) regs_i (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .addr      (addr),
        .wdata     (wdata),
        .start     (start),
        .rdata     (rdata),
        .done      (done),
        .op_a      (op_a),
        .op_b      (op_b),
        .ctrl      (ctrl),
        .res       (res),
        .carry_out (carry_out),
        .zero      (zero)
    );

    alu_chain #(.SLICES(SLICES)) chain_i (
        .op_a      (op_a),
        .op_b      (op_b),
        .ctrl      (ctrl),
        .res       (res),
        .carry_out (carry_out),
        .zero      (zero)
    );

endmodule

`default_nettype wire

/* test/alu_model.svh */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// expected result, carry and zero of one command on width-bit operands
task automatic compute_expected(
    input  AluCmd            cmd,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] res,
    output logic             carry,
    output logic             zero
);
    logic [WIDTH:0] sum;
    sum   = '0;
    res   = '0;
    carry = 1'b0;
    case (cmd)
        ADD: begin
            sum   = {1'b0, a} + {1'b0, b};
            res   = sum[WIDTH-1:0];
            carry = sum[WIDTH];          // carry out of the top bit
        end
        SUB: begin
            res   = a - b;
            carry = (a >= b);            // no borrow
        end
        COMP: begin
            res   = a - b - WIDTH'(1);
            carry = (a > b);
        end
        XOR:  res = a ^ b;
        XNOR: res = ~(a ^ b);
        AND:  res = a & b;
        OR:   res = a | b;
        default: res = '0;
    endcase
    zero = (res == '0);
endtask

task automatic check_result(
    input string            name,
    input logic [WIDTH-1:0] got,
    input logic [WIDTH-1:0] exp
);
    if (got !== exp) begin
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        report_failure();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        report_failure();
    end
endtask

task automatic check_cmd(input string name, input AluCtrl got, input AluCtrl exp);
    logic [4:0] got_bits;
    logic [4:0] exp_bits;
    got_bits = got;
    exp_bits = exp;
    if (got_bits !== exp_bits) begin
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got_bits, exp_bits);
        report_failure();
    end
endtask

`endif

/* test/tb_alu_top.sv */
`default_nettype none

module tb_alu_top;

    import alu_pkg::*;

    localparam int SLICES       = 4;
    localparam int WIDTH        = 4 * SLICES;
    localparam int DONE_TIMEOUT = 10;

    logic             clk;
    logic             rst;
    logic             wr;
    reg_addr_e        addr;
    logic [WIDTH-1:0] wdata;
    logic             start;
    logic [WIDTH+1:0] rdata;
    logic             done;

    int seed = 32'h597e;

    logic [WIDTH-1:0] exp_a;    // register contents as the host wrote them
    logic [WIDTH-1:0] exp_b;
    AluCtrl           exp_cmd;

    alu_top #(.SLICES(SLICES)) dut_i (
        .clk   (clk),
        .rst   (rst),
        .wr    (wr),
        .addr  (addr),
        .wdata (wdata),
        .start (start),
        .rdata (rdata),
        .done  (done)
    );

    always #5 clk = ~clk;

    task automatic report_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    `include "alu_model.svh"

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic logic [WIDTH-1:0] rand_word();
        logic [31:0] r;
        r = next_rand();
        return r[WIDTH-1:0];
    endfunction

    // zero and all-ones show up often
    function automatic logic [WIDTH-1:0] pick_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0:    return '0;
            3'd1:    return '1;
            default: return rand_word();
        endcase
    endfunction

    function automatic AluCmd random_cmd();
        logic [31:0] r;
        r = next_rand();
        case (r % 7)
            0:       return ADD;
            1:       return SUB;
            2:       return XOR;
            3:       return XNOR;
            4:       return COMP;
            5:       return AND;
            default: return OR;
        endcase
    endfunction

    function automatic logic legal_code(logic [4:0] code);
        case (code)
            ADD, SUB, XOR, XNOR, COMP, AND, OR: return 1'b1;
            default:                            return 1'b0;
        endcase
    endfunction

    task automatic write_reg(input reg_addr_e a, input logic [WIDTH-1:0] d);
        @(negedge clk);
        wr    = 1'b1;
        addr  = a;
        wdata = d;
        start = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_e a, output logic [WIDTH+1:0] val);
        @(negedge clk);
        wr    = 1'b0;
        start = 1'b0;
        addr  = a;
        #1;
        val = rdata;
    endtask

    task automatic expect_readback(input reg_addr_e a, input logic [WIDTH-1:0] exp);
        logic [WIDTH+1:0] val;
        read_reg(a, val);
        check_result($sformatf("%s readback", a.name()), val[WIDTH-1:0], exp);
        check_result("rdata upper bits", WIDTH'(val[WIDTH+1:WIDTH]), '0);
    endtask

    task automatic expect_cmd_readback();
        logic [WIDTH+1:0] val;
        AluCtrl           got;
        read_reg(REG_CMD, val);
        got = val[4:0];
        check_cmd("REG_CMD readback", got, exp_cmd);
        check_result("REG_CMD upper bits", WIDTH'(val[WIDTH+1:5]), '0);
    endtask

    // rdata must already show REG_STATUS
    task automatic compare_status(input logic [WIDTH-1:0] r, input logic c, input logic z);
        check_result("status result", rdata[WIDTH+1:2], r);
        check_flag("status carry", rdata[1], c);
        check_flag("status zero", rdata[0], z);
    endtask

    task automatic wait_done(output int cycles);
        cycles = 1;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("timeout: done did not rise within %0d cycles of start", DONE_TIMEOUT);
            report_failure();
        end
    endtask

    task automatic run_op(input AluCmd cmd, input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
        logic [WIDTH-1:0] er;
        logic             ec;
        logic             ez;
        int               cycles;
        AluCtrl           c;
        c.cmd = cmd;
        write_reg(REG_A, a);
        write_reg(REG_B, b);
        write_reg(REG_CMD, {{(WIDTH-5){1'b0}}, c});
        exp_a   = a;
        exp_b   = b;
        exp_cmd = c;
        compute_expected(cmd, a, b, er, ec, ez);
        @(negedge clk);
        wr    = 1'b0;
        addr  = REG_STATUS;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_done(cycles);
        if (cycles != 1) begin
            $display("done came %0d cycles after start instead of 1", cycles);
            report_failure();
        end
        #1;
        compare_status(er, ec, ez);
        @(negedge clk);
        check_flag("done", done, 1'b0);    // one cycle pulse only
    endtask

    task automatic reset_values();
        logic [WIDTH+1:0] val;
        expect_readback(REG_A, '0);
        expect_readback(REG_B, '0);
        expect_cmd_readback();
        read_reg(REG_STATUS, val);
        compare_status('0, 1'b0, 1'b0);
        check_flag("done", done, 1'b0);
    endtask

    task automatic register_access();
        logic [WIDTH-1:0] d;
        logic [WIDTH+1:0] val;
        logic [31:0]      r;
        AluCtrl           c;
        repeat (20) begin
            d = rand_word();
            write_reg(REG_A, d);
            exp_a = d;
            expect_readback(REG_A, exp_a);
            d = rand_word();
            write_reg(REG_B, d);
            exp_b = d;
            expect_readback(REG_B, exp_b);
            c.cmd = random_cmd();
            write_reg(REG_CMD, {{(WIDTH-5){1'b0}}, c});
            exp_cmd = c;
            expect_cmd_readback();
            r = next_rand();
            while (legal_code(r[4:0])) begin
                r = next_rand();
            end
            write_reg(REG_CMD, {{(WIDTH-5){1'b0}}, r[4:0]});   // must be dropped
            expect_cmd_readback();
            write_reg(REG_STATUS, rand_word());
            expect_readback(REG_A, exp_a);
            expect_readback(REG_B, exp_b);
            expect_cmd_readback();
            read_reg(REG_STATUS, val);
            compare_status('0, 1'b0, 1'b0);     // nothing captured yet
            check_flag("done", done, 1'b0);     // no start so far
        end
    endtask

    task automatic arith_ops();
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [31:0]      r;
        AluCmd            cmd;
        repeat (300) begin
            r = next_rand();
            case (r % 3)
                0:       cmd = ADD;
                1:       cmd = SUB;
                default: cmd = COMP;
            endcase
            a = pick_operand();
            b = (r[5:4] == 2'd0) ? a : pick_operand();
            run_op(cmd, a, b);
        end
    endtask

    task automatic logic_ops();
        logic [WIDTH-1:0] a;
        logic [31:0]      r;
        AluCmd            cmd;
        for (int i = 0; i < 300; i++) begin
            r = next_rand();
            a = pick_operand();
            if (i % 10 == 0) begin
                run_op(ADD, a, a);             // shift left by one
            end else if (i % 10 == 5) begin
                run_op(XNOR, '0, pick_operand());  // not of b
            end else begin
                case (r[1:0])
                    2'd0:    cmd = XOR;
                    2'd1:    cmd = XNOR;
                    2'd2:    cmd = AND;
                    default: cmd = OR;
                endcase
                run_op(cmd, a, pick_operand());
            end
        end
    endtask

    // alternate a write cycle and a status read cycle with start high in both
    task automatic back_to_back();
        logic [WIDTH-1:0] cap_res;
        logic             cap_carry;
        logic             cap_zero;
        logic [WIDTH-1:0] new_val;
        logic [31:0]      r;
        AluCtrl           c;
        c.cmd = random_cmd();
        write_reg(REG_CMD, {{(WIDTH-5){1'b0}}, c});
        exp_cmd = c;
        for (int i = 0; i < 24; i++) begin
            r       = next_rand();
            new_val = pick_operand();
            @(negedge clk);
            if (i > 0) begin
                check_flag("done", done, 1'b1);
            end
            compute_expected(exp_cmd.cmd, exp_a, exp_b, cap_res, cap_carry, cap_zero);
            start = 1'b1;
            wr    = 1'b1;
            wdata = new_val;
            if (r[0]) begin
                addr  = REG_A;
                exp_a = new_val;
            end else begin
                addr  = REG_B;
                exp_b = new_val;
            end
            @(negedge clk);
            check_flag("done", done, 1'b1);
            start = 1'b1;
            wr    = 1'b0;
            addr  = REG_STATUS;
            #1;
            compare_status(cap_res, cap_carry, cap_zero);   // pre-write operands
            compute_expected(exp_cmd.cmd, exp_a, exp_b, cap_res, cap_carry, cap_zero);
        end
        @(negedge clk);
        check_flag("done", done, 1'b1);
        start = 1'b0;
        #1;
        compare_status(cap_res, cap_carry, cap_zero);
        @(negedge clk);
        check_flag("done", done, 1'b0);
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        wr      = 1'b0;
        addr    = REG_A;
        wdata   = '0;
        start   = 1'b0;
        exp_a   = '0;
        exp_b   = '0;
        exp_cmd = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        reset_values();
        register_access();
        arith_ops();
        logic_ops();
        back_to_back();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+test
src/alu_pkg.sv
src/full_adder.sv
src/alu.sv
src/alu_chain.sv
src/alu_regs.sv
src/alu_top.sv
test/tb_alu_top.sv

/* run.sh */
#!/bin/sh
# build and run the ALU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_alu_top

./obj_dir/Vtb_alu_top | tee sim.log

if grep -qxF "Simulation completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
